/* logic/execPkg.sv */
// Types shared by the data-processing execute cluster
// Opcode and shift encodings with the NZCV flag struct
// Request, shift-stage and result payloads

package execPkg;

    parameter int dataW = 32; // Data word width

    // ARM data-processing opcodes
    // Codes without a name here behave as MOV in the ALU
    typedef enum logic [3:0] {
        OpAnd = 4'b0000,
        OpEor = 4'b0001,
        OpSub = 4'b0010,
        OpRsb = 4'b0011,
        OpAdd = 4'b0100,
        OpAdc = 4'b0101,
        OpSbc = 4'b0110,
        OpOrr = 4'b1100,
        OpMov = 4'b1101,
        OpBic = 4'b1110,
        OpMvn = 4'b1111
    } aluOpT;

    // Operand 2 shift encodings, instruction bits [6:5]
    typedef enum logic [1:0] {
        ShLsl = 2'b00,
        ShLsr = 2'b01,
        ShAsr = 2'b10,
        ShRor = 2'b11
    } shiftTypeT;

    typedef struct packed {
        logic n;
        logic z;
        logic c;
        logic v;
    } flagsT;

    // Decoded operation as it enters the cluster
    typedef struct packed {
        aluOpT            op;
        shiftTypeT        shiftType;
        logic [4:0]       shiftAmt;
        logic             rrx;       // ROR #0 means RRX
        logic [dataW-1:0] opA;
        logic [dataW-1:0] opB;       // Unshifted operand 2
        flagsT            flagsIn;
    } execReqT;

    // Between the shifter and the ALU
    typedef struct packed {
        aluOpT            op;
        logic [dataW-1:0] opA;
        logic [dataW-1:0] shiftedB;
        logic             shiftCarry;
        flagsT            flagsIn;
    } shiftedT;

    typedef struct packed {
        logic [dataW-1:0] result;
        flagsT            flags;
    } execResT;

endpackage

/* logic/barrelShifter.sv */
// Barrel shifter for operand 2
// LSL, LSR, ASR, ROR and RRX with the shifter carry-out

`timescale 1ns/1ps

module barrelShifter (
    input  execPkg::shiftTypeT         shiftType,
    input  logic [4:0]                 shiftAmt,
    input  logic                       rrx,
    input  logic                       carryIn,
    input  logic [execPkg::dataW-1:0]  value,
    output logic [execPkg::dataW-1:0]  shifted,
    output logic                       carryOut
);
    import execPkg::*;

    logic [dataW:0]     lslWide;  // Extra MSB catches the last bit out
    logic [dataW:0]     lsrWide;  // Extra LSB catches the last bit out
    logic [dataW:0]     asrWide;
    logic [2*dataW-1:0] rotWide;

    always_comb begin
        lslWide = {1'b0, value} << shiftAmt;
        lsrWide = {value, 1'b0} >> shiftAmt;
        asrWide = $signed({value, 1'b0}) >>> shiftAmt;
        rotWide = {value, value} >> shiftAmt;

        // Amount 0 passes through unless RRX
        shifted  = value;
        carryOut = carryIn;

        if (shiftAmt == '0) begin
            if (shiftType == ShRor && rrx) begin
                shifted  = {carryIn, value[dataW-1:1]}; // RRX
                carryOut = value[0];
            end
        end else begin
            case (shiftType)
                ShLsl: begin
                    shifted  = lslWide[dataW-1:0];
                    carryOut = lslWide[dataW];
                end
                ShLsr: begin
                    shifted  = lsrWide[dataW:1];
                    carryOut = lsrWide[0];
                end
                ShAsr: begin
                    shifted  = asrWide[dataW:1];
                    carryOut = asrWide[0];
                end
                default: begin // ROR
                    shifted  = rotWide[dataW-1:0];
                    carryOut = rotWide[dataW-1]; // Last bit rotated round
                end
            endcase
        end
    end

endmodule

/* logic/aluCore.sv */
// Data-processing ALU
// One shared adder for the arithmetic ops, bitwise logic for the rest
// NZCV generation from the result, adder and shifter carry

`timescale 1ns/1ps

module aluCore (
    input  execPkg::aluOpT             op,
    input  logic [execPkg::dataW-1:0]  opA,
    input  logic [execPkg::dataW-1:0]  opB,
    input  logic                       shiftCarry,
    input  execPkg::flagsT             flagsIn,
    output logic [execPkg::dataW-1:0]  result,
    output execPkg::flagsT             flags
);
    import execPkg::*;

    logic [dataW-1:0] addA;
    logic [dataW-1:0] addB;
    logic             addCin;
    logic             isArith;
    logic [dataW:0]   sum;      // Bit dataW is the adder carry
    logic             overflow;
    logic [dataW-1:0] logicRes;

    // Adder operand steering
    always_comb begin
        addA    = opA;
        addB    = opB;
        addCin  = 1'b0;
        isArith = 1'b1;
        case (op)
            OpSub: begin
                addB   = ~opB;
                addCin = 1'b1;
            end
            OpRsb: begin
                addA   = opB; // B - A
                addB   = ~opA;
                addCin = 1'b1;
            end
            OpAdd: addCin = 1'b0;
            OpAdc: addCin = flagsIn.c;
            OpSbc: begin
                addB   = ~opB;
                addCin = flagsIn.c; // A - B - !C
            end
            default: isArith = 1'b0;
        endcase
    end

    assign sum      = {1'b0, addA} + {1'b0, addB} + {{dataW{1'b0}}, addCin};
    assign overflow = (addA[dataW-1] == addB[dataW-1]) && (sum[dataW-1] != addA[dataW-1]);

    always_comb begin
        case (op)
            OpAnd:   logicRes = opA & opB;
            OpEor:   logicRes = opA ^ opB;
            OpOrr:   logicRes = opA | opB;
            OpBic:   logicRes = opA & ~opB;
            OpMvn:   logicRes = ~opB;
            default: logicRes = opB; // MOV and unnamed codes
        endcase
    end

    always_comb begin
        result  = isArith ? sum[dataW-1:0] : logicRes;
        flags.n = result[dataW-1];
        flags.z = (result == '0);
        flags.c = isArith ? sum[dataW] : shiftCarry; // Not-borrow on subtract
        flags.v = isArith ? overflow : flagsIn.v;
    end

endmodule

/* logic/stageReg.sv */
// One-entry valid/ready pipeline register
// Payload type is a parameter

`timescale 1ns/1ps

module stageReg #(
    parameter type payloadT = logic
) (
    input  logic    clk,
    input  logic    arstN,
    input  logic    inValid,
    output logic    inReady,
    input  payloadT inData,
    output logic    outValid,
    input  logic    outReady,
    output payloadT outData
);

    logic    full;
    payloadT data;

    // Empty or draining this cycle, so no bubble
    assign inReady = !full || outReady;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            full <= 1'b0;
        end else if (inReady) begin
            full <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        if (inValid && inReady) data <= inData;
    end

    assign outValid = full;
    assign outData  = data;

endmodule

/* logic/execLane.sv */
// One execute lane
// Stage A holds the request, the shifter feeds stage B
// ALU works on stage B's output

`timescale 1ns/1ps

module execLane (
    input  logic              clk,
    input  logic              arstN,
    input  logic              inValid,
    output logic              inReady,
    input  execPkg::execReqT  inReq,
    output logic              outValid,
    input  logic              outReady,
    output execPkg::execResT  outRes
);
    import execPkg::*;

    logic             aValid;
    logic             aReady;
    execReqT          aReq;
    logic [dataW-1:0] shOut;
    logic             shCarry;
    shiftedT          shNext;
    shiftedT          bData;
    logic [dataW-1:0] aluResult;
    flagsT            aluFlags;

    stageReg #(.payloadT(execReqT)) stageA (
        .clk(clk), .arstN(arstN),
        .inValid(inValid), .inReady(inReady), .inData(inReq),
        .outValid(aValid), .outReady(aReady), .outData(aReq)
    );

    barrelShifter shifter (
        .shiftType(aReq.shiftType), .shiftAmt(aReq.shiftAmt), .rrx(aReq.rrx),
        .carryIn(aReq.flagsIn.c), .value(aReq.opB),
        .shifted(shOut), .carryOut(shCarry)
    );

    assign shNext = '{op: aReq.op, opA: aReq.opA, shiftedB: shOut,
                      shiftCarry: shCarry, flagsIn: aReq.flagsIn};

    stageReg #(.payloadT(shiftedT)) stageB (
        .clk(clk), .arstN(arstN),
        .inValid(aValid), .inReady(aReady), .inData(shNext),
        .outValid(outValid), .outReady(outReady), .outData(bData)
    );

    aluCore alu (
        .op(bData.op), .opA(bData.opA), .opB(bData.shiftedB),
        .shiftCarry(bData.shiftCarry), .flagsIn(bData.flagsIn),
        .result(aluResult), .flags(aluFlags)
    );

    assign outRes = '{result: aluResult, flags: aluFlags}; // Combinational from stage B

endmodule

/* logic/opDispatcher.sv */
// Round-robin dispatcher from the request port to the lanes
// Valid goes only to the pointed lane, its ready comes back

`timescale 1ns/1ps

module opDispatcher #(
    parameter int NumLanes = 4
) (
    input  logic                clk,
    input  logic                arstN,
    input  logic                reqValid,
    output logic                reqReady,
    output logic [NumLanes-1:0] laneValid,
    input  logic [NumLanes-1:0] laneReady
);

    localparam int PtrW = (NumLanes > 1) ? $clog2(NumLanes) : 1;

    logic [PtrW-1:0] lanePtr;
    logic            lastLane;

    assign lastLane = (lanePtr == PtrW'(NumLanes - 1));

    always_comb begin
        laneValid          = '0;
        laneValid[lanePtr] = reqValid;
    end

    assign reqReady = laneReady[lanePtr];

    // Step on every accepted request
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            lanePtr <= '0;
        end else if (reqValid && reqReady) begin
            if (lastLane) begin
                lanePtr <= '0;
            end else begin
                lanePtr <= lanePtr + 1'b1;
            end
        end
    end

endmodule

/* logic/resultCollector.sv */
// In-order round-robin drain of the lanes
// One-entry registered output port

`timescale 1ns/1ps

module resultCollector #(
    parameter int NumLanes = 4
) (
    input  logic                clk,
    input  logic                arstN,
    input  logic [NumLanes-1:0] laneValid,
    output logic [NumLanes-1:0] laneReady,
    input  execPkg::execResT    laneRes [NumLanes],
    output logic                resValid,
    input  logic                resReady,
    output execPkg::execResT    res
);

    localparam int PtrW = (NumLanes > 1) ? $clog2(NumLanes) : 1;

    logic [PtrW-1:0] drainPtr;
    logic            canTake;  // Output slot free this cycle
    logic            take;

    assign canTake = !resValid || resReady;
    assign take    = laneValid[drainPtr] && canTake;

    always_comb begin
        laneReady           = '0;
        laneReady[drainPtr] = canTake;
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            resValid <= 1'b0;
            drainPtr <= '0;
        end else begin
            if (take) resValid <= 1'b1;
            else if (resReady) resValid <= 1'b0;
            if (take) begin
                drainPtr <= (drainPtr == PtrW'(NumLanes - 1)) ? '0 : drainPtr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) res <= laneRes[drainPtr];
    end

endmodule

/* logic/execCluster.sv */
// Execute cluster top level
// Dispatcher, NumLanes execute lanes and the in-order collector

`timescale 1ns/1ps

module execCluster #(
    parameter int NumLanes = 4
) (
    input  logic              clk,
    input  logic              arstN,
    input  logic              reqValid,
    output logic              reqReady,
    input  execPkg::execReqT  req,
    output logic              resValid,
    input  logic              resReady,
    output execPkg::execResT  res
);
    import execPkg::*;

    logic [NumLanes-1:0] laneInValid;
    logic [NumLanes-1:0] laneInReady;
    logic [NumLanes-1:0] laneOutValid;
    logic [NumLanes-1:0] laneOutReady;
    execResT             laneRes [NumLanes];

    opDispatcher #(.NumLanes(NumLanes)) dispatcher (
        .clk(clk), .arstN(arstN),
        .reqValid(reqValid), .reqReady(reqReady),
        .laneValid(laneInValid), .laneReady(laneInReady)
    );

    // Request payload fans out to every lane
    for (genvar i = 0; i < NumLanes; i++) begin : gLane
        execLane lane (
            .clk(clk), .arstN(arstN),
            .inValid(laneInValid[i]), .inReady(laneInReady[i]), .inReq(req),
            .outValid(laneOutValid[i]), .outReady(laneOutReady[i]), .outRes(laneRes[i])
        );
    end

    resultCollector #(.NumLanes(NumLanes)) collector (
        .clk(clk), .arstN(arstN),
        .laneValid(laneOutValid), .laneReady(laneOutReady), .laneRes(laneRes),
        .resValid(resValid), .resReady(resReady), .res(res)
    );

endmodule

/* sim/tbClock.sv */
// Testbench clock generator
// Free-running, starts low

`timescale 1ns/1ps

module tbClock #(
    parameter int PeriodNs = 20
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PeriodNs / 2) clk = ~clk; // Half period per phase
    end

endmodule

/* sim/execClusterChecker.sv */
// Handshake and reset assertions for the execute cluster
// Bound into every execCluster instance

`timescale 1ns/1ps

module execClusterChecker (
    input logic             clk,
    input logic             arstN,
    input logic             reqValid,
    input logic             reqReady,
    input execPkg::execReqT req,
    input logic             resValid,
    input logic             resReady,
    input execPkg::execResT res
);

    int failCount = 0; // Failed assertions so far

    resetIdle: assert property (@(posedge clk) !arstN |-> !resValid)
        else begin
            failCount++;
            $error("resValid high while in reset");
        end

    resHold: assert property (@(posedge clk) disable iff (!arstN)
        resValid && !resReady |=> $stable(res))
        else begin
            failCount++;
            $error("res changed while the output port was stalled");
        end

    // Source side must hold the request until it is taken
    reqHold: assert property (@(posedge clk) disable iff (!arstN)
        reqValid && !reqReady |=> $stable(req))
        else begin
            failCount++;
            $error("req changed while the input port was stalled");
        end

    resKnown: assert property (@(posedge clk) disable iff (!arstN)
        resValid |-> !$isunknown(res))
        else begin
            failCount++;
            $error("res carries X or Z while resValid is high");
        end

endmodule

bind execCluster execClusterChecker handshakeChk (
    .clk(clk), .arstN(arstN),
    .reqValid(reqValid), .reqReady(reqReady), .req(req),
    .resValid(resValid), .resReady(resReady), .res(res)
);

/* sim/execClusterTb.sv */
// Testbench for the execute cluster
// Trace-driven stimulus, in-order result checks, latency checks and a watchdog

`timescale 1ns/1ps

module execClusterTb;
    import execPkg::*;

    localparam int MaxEntries = 64;
    localparam int NumTests   = 6;

    logic    clk;
    logic    arstN;
    logic    reqValid;
    logic    reqReady;
    execReqT req;
    logic    resValid;
    logic    resReady;
    execResT res;

    // test[123:116] req[115:36] expResult[35:4] expFlags[3:0]
    logic [123:0] trace [MaxEntries];
    int           numEntries = 0;
    int           cycle      = 0;
    int           errors     = 0;
    int           checked    = 0;
    int           seed;
    int           expQ[$];    // Trace index per accepted request
    int           acceptQ[$]; // Acceptance cycle, same order

    tbClock #(.PeriodNs(20)) clkGen (.clk(clk));

    execCluster #(.NumLanes(4)) dut (
        .clk(clk), .arstN(arstN),
        .reqValid(reqValid), .reqReady(reqReady), .req(req),
        .resValid(resValid), .resReady(resReady), .res(res)
    );

    always @(posedge clk) cycle <= cycle + 1;

    task automatic compareResult(input string name, input logic [dataW-1:0] exp,
                                 input logic [dataW-1:0] act);
        if (act !== exp) begin
            $display("Mismatch at %0t: %s expected %08h, got %08h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic compareFlags(input string name, input flagsT exp, input flagsT act);
        if (act !== exp) begin
            $display("Mismatch at %0t: %s expected nzcv %04b, got %04b", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic applyReset();
        @(negedge clk);
        arstN = 1'b0;
        repeat (16) @(negedge clk);
        if (resValid !== 1'b0) begin
            $display("resValid was not low during reset at %0t", $time);
            errors++;
        end
        arstN = 1'b1;
    endtask

    // Streams entries first..last, passes times over, and drains every result
    task automatic runTest(input int first, input int last, input bit randReady,
                           input int passes);
        int count;
        int total;
        int sent;
        int got;
        int idx;
        int lat;
        int stalls;
        count  = last - first + 1;
        total  = count * passes;
        sent   = 0;
        got    = 0;
        stalls = 0;
        while (got < total) begin
            @(negedge clk);
            reqValid = (sent < total);
            if (sent < total) req = execReqT'(trace[first + sent % count][115:36]);
            resReady = randReady ? 1'($random(seed)) : 1'b1;
            #1;
            if (reqValid && !reqReady) begin
                stalls++;
                if (!randReady) begin
                    $display("Request stalled at %0t without back-pressure", $time);
                    errors++;
                end
            end
            if (reqValid && reqReady) begin // Taken at the next rising edge
                expQ.push_back(first + sent % count);
                acceptQ.push_back(cycle);
                sent++;
            end
            if (resValid && resReady) begin
                got++;
                if (expQ.size() == 0) begin
                    $display("Result at %0t with no request outstanding", $time);
                    errors++;
                end else begin
                    idx = expQ.pop_front();
                    lat = cycle - acceptQ.pop_front();
                    compareResult("res.result", trace[idx][35:4], res.result);
                    compareFlags("res.flags", flagsT'(trace[idx][3:0]), res.flags);
                    if (!randReady && lat != 3) begin
                        $display("Result at %0t came %0d cycles after acceptance, not 3",
                                 $time, lat);
                        errors++;
                    end
                    checked++;
                end
            end
        end
        if (randReady && stalls == 0) begin
            $display("Back-pressure never reached the request port");
            errors++;
        end
    endtask

    initial begin
        int first;
        int last;
        int passes;
        int errBefore;
        int expected;
        arstN    = 1'b0;
        reqValid = 1'b0;
        req      = '0;
        resReady = 1'b1;
        seed     = 32'h39e0;
        expected = 0;
        for (int i = 0; i < MaxEntries; i++) begin
            trace[i] = '0;
        end
        $readmemh("sim/execTrace.txt", trace);
        for (int i = 0; i < MaxEntries; i++) begin
            if (trace[i][123:116] != 8'h00) numEntries++;
        end
        applyReset();
        for (int t = 1; t <= NumTests; t++) begin
            first = -1;
            last  = -1;
            for (int i = 0; i < numEntries; i++) begin
                if (int'(trace[i][123:116]) == t) begin
                    if (first < 0) first = i;
                    last = i;
                end
            end
            if (t == 6) applyReset(); // Second reset mid-run
            errBefore = errors;
            if (first < 0) begin
                $display("Test %0d has no entries in the trace", t);
                errors++;
            end else begin
                passes = (t == 5) ? 3 : 1; // Replays let the lanes fill up
                runTest(first, last, t == 5, passes); // Test 5 uses random resReady
                expected += (last - first + 1) * passes;
                $display("Test %0d: %0d operations, %s", t, (last - first + 1) * passes,
                         (errors == errBefore) ? "ok" : "errors found");
            end
        end
        $display("Checked %0d of %0d results, %0d errors, %0d assertion failures",
                 checked, expected, errors, dut.handshakeChk.failCount);
        if (errors == 0 && checked == expected && dut.handshakeChk.failCount == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // Watchdog sized from the trace length
    initial begin
        wait (numEntries > 0);
        repeat (numEntries * 40 + 200) @(posedge clk);
        $display("Timeout at cycle %0d: results stopped arriving", cycle);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

/* sim/execTrace.txt */
// test_ctrl{op,shType,amt,rrx}_opA_opB_flagsIn_expResult_expFlags (flags are nzcv)
// ctrl: op[11:8] shType[7:6] amt[5:1] rrx[0]
01_008_FFFF0000_00000F0F_1_00000000_5
01_150_12345678_FF00FF80_0_12CB5687_2
01_C02_00000001_80000000_1_00000001_3
01_D00_00000000_80000000_2_80000000_A
01_E7E_FFFFFFFF_80000000_C_FFFFFFFE_8
01_F3E_00000000_00000003_1_7FFFFFFF_3
02_D88_00000000_F0000008_0_FF000000_A
02_DBE_00000000_80000000_2_FFFFFFFF_8
02_DD0_00000000_123456F8_0_F8123456_A
02_DC1_00000000_00000003_0_00000001_2
02_DC1_00000000_00000002_2_80000001_8
02_DC0_00000000_00000000_2_00000000_6
02_040_00FF00FF_0000FFFF_0_000000FF_0
03_400_7FFFFFFF_00000001_0_80000000_9
03_400_FFFFFFFF_00000001_0_00000000_6
03_200_00000005_00000005_0_00000000_6
03_200_00000003_00000005_0_FFFFFFFE_8
03_200_80000000_00000001_0_7FFFFFFF_3
03_308_00000010_00000002_0_00000010_2
03_500_00000001_FFFFFFFE_2_00000000_6
03_600_00000005_00000005_0_FFFFFFFF_8
03_600_7FFFFFFF_FFFFFFFF_2_80000000_9
04_400_00000001_00000002_0_00000003_0
04_208_00000010_00000001_0_00000000_6
04_100_AAAAAAAA_55555555_0_FFFFFFFF_8
04_CD0_0F000000_000000F0_0_FF000000_A
04_D42_00000000_00000001_0_00000000_6
04_300_00000001_00000000_0_FFFFFFFF_8
05_400_00000100_00000200_0_00000300_0
05_410_00000100_00000001_0_00000200_0
05_200_00000000_00000001_0_FFFFFFFF_8
05_000_F0F0F0F0_0FF00FF0_2_00F000F0_2
05_F00_00000000_00000000_0_FFFFFFFF_8
05_500_80000000_80000000_0_00000000_7
05_100_12345678_12345678_1_00000000_5
05_D82_00000000_80000001_0_C0000000_A
05_300_00000001_00000005_0_00000004_2
06_400_00000005_00000005_0_0000000A_0
06_200_00000001_00000002_0_FFFFFFFF_8

/* tb.f */
logic/execPkg.sv
logic/barrelShifter.sv
logic/aluCore.sv
logic/stageReg.sv
logic/execLane.sv
logic/opDispatcher.sv
logic/resultCollector.sv
logic/execCluster.sv
sim/tbClock.sv
sim/execClusterChecker.sv
sim/execClusterTb.sv

/* runSim.sh */
#!/bin/sh
# Build and run the execute cluster testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
    -f tb.f --top-module execClusterTb
./obj_dir/VexecClusterTb +verilator+error+limit+100 > sim.log 2>&1
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log || ! grep -q "TEST RESULT: PASS" sim.log; then
    exit 1
fi
exit 0
